/* logic/link_params.svh */
`ifndef LINK_PARAMS_SVH
`define LINK_PARAMS_SVH

// number of remote digitizer boards, one COUT/DOUT lane pair each
`define NUM_LANES 7

// idle training pattern a board drives on DOUT while its outputs are in training
`define DOUT_TRAIN 8'h6A

// consecutive all-ones COUT cycles before a lane counts as lost
`define COUT_LOSS_COUNT 16

// stand-in for deserializer lock, in sys_clk cycles
`define LOCK_CYCLES 8

// register map
// control, holds the lane enable mask
`define REG_CTRL 2'd0
// live and boot flags, read only
`define REG_STATUS 2'd1
// train_in_req, train_out_rdy and misaligned flags, read only
`define REG_FLAGS 2'd2
// last training event, written by the sequencer
`define REG_EVENT 2'd3

`endif

/* logic/link_pkg.sv */
package link_pkg;

    // one bit per remote board
    typedef logic [6:0] lane_mask_t;

    // raw lane codes
    typedef logic [3:0] cout_code_t;
    typedef logic [7:0] dout_code_t;

    // lane number, fits all seven boards
    typedef logic [2:0] lane_idx_t;

    // register bus fields
    typedef logic [1:0] reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // one register bus transfer, strobes are single cycle
    typedef struct packed {
        logic wr;
        logic rd;
        reg_addr_t addr;
        reg_data_t wdata;
    } bus_req_t;

    // per-lane link state as seen by the detector
    typedef struct packed {
        lane_mask_t boot;
        lane_mask_t train_in_req;
        lane_mask_t train_out_rdy;
        lane_mask_t live;
        lane_mask_t misaligned;
    } link_status_t;

    // autostart sequencer states
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_LOCK,
        SEQ_LOG,
        SEQ_WAIT_GNT
    } seq_state_t;

endpackage

/* logic/link_live_detector.sv */
`timescale 1ns/1ps
`include "link_params.svh"

// boards come up slower than we do, so every lane starts not booted
// a COUT stuck at all ones means the board lost its clock and reset its outputs
// DOUT dropping to zero after boot asks us to train our inputs to the board
// COUT leaving all ones afterwards says the board's outputs are in training
// once training completes, DOUT must go 0x6A -> 0x00 and anything else is misaligned
module link_live_detector
    import link_pkg::*;
(
    input  logic                             sys_clk_i,
    input  logic                             sys_clk_ok_i,
    // four COUT bits per lane
    input  cout_code_t [`NUM_LANES-1:0]      cout_i,
    // eight DOUT bits per lane
    input  dout_code_t [`NUM_LANES-1:0]      dout_i,
    // from the autostart sequencer
    input  lane_mask_t                       train_complete_i,
    output link_status_t                     status_o,
    // one cycle pulse per lane when the loss counter hits terminal count
    output lane_mask_t                       link_lost_o
);

    // per-lane results gathered on nets, each lane drives only its own bit
    wire lane_mask_t boot_w;
    wire lane_mask_t train_in_req_w;
    wire lane_mask_t train_out_rdy_w;
    wire lane_mask_t live_w;
    wire lane_mask_t misaligned_w;
    wire lane_mask_t lost_w;

    genvar i;
    generate
        for (i = 0; i < `NUM_LANES; i = i + 1) begin : g_lane
            logic       boot_q;
            logic       train_in_req_q;
            logic       train_out_rdy_q;
            logic       live_q;
            logic       misaligned_q;
            logic [4:0] loss_cnt_q;
            logic       cout_high;
            logic       dout_null;
            logic       dout_out_of_train;
            logic       lost;

            assign cout_high = (cout_i[i] == 4'hF);
            assign dout_null = (dout_i[i] == 8'h00);
            // only meaningful once the sequencer says this lane is locked
            assign dout_out_of_train = train_complete_i[i] && (dout_i[i] != `DOUT_TRAIN);
            // terminal count of the loss counter
            assign lost = (loss_cnt_q == 5'(`COUT_LOSS_COUNT));

            always_ff @(posedge sys_clk_i or negedge sys_clk_ok_i) begin
                if (!sys_clk_ok_i) begin
                    loss_cnt_q <= '0;
                end else if ((live_q || !boot_q) && cout_high) begin
                    // keep counting through terminal count while the run lasts
                    loss_cnt_q <= lost ? 5'd1 : loss_cnt_q + 5'd1;
                end else begin
                    // only watch for loss while live, or before the first boot
                    loss_cnt_q <= '0;
                end
            end

            always_ff @(posedge sys_clk_i or negedge sys_clk_ok_i) begin
                if (!sys_clk_ok_i) begin
                    boot_q          <= 1'b0;
                    train_in_req_q  <= 1'b0;
                    train_out_rdy_q <= 1'b0;
                    live_q          <= 1'b0;
                    misaligned_q    <= 1'b0;
                end else begin
                    // once seen, boot stays set; a lost live lane counts as booted again
                    if (lost) begin
                        boot_q <= 1'b1;
                    end

                    if (lost) begin
                        train_in_req_q <= 1'b0;
                    end else if (dout_null && boot_q) begin
                        train_in_req_q <= 1'b1;
                    end

                    if (lost) begin
                        train_out_rdy_q <= 1'b0;
                    end else if (train_in_req_q && !cout_high) begin
                        train_out_rdy_q <= 1'b1;
                    end

                    if (lost) begin
                        live_q <= 1'b0;
                    end else if (dout_out_of_train) begin
                        live_q <= 1'b1;
                    end

                    // sticky until reset, a bad 0x6A exit should never happen
                    if (dout_out_of_train && !dout_null) begin
                        misaligned_q <= 1'b1;
                    end
                end
            end

            assign boot_w[i]          = boot_q;
            assign train_in_req_w[i]  = train_in_req_q;
            assign train_out_rdy_w[i] = train_out_rdy_q;
            assign live_w[i]          = live_q;
            assign misaligned_w[i]    = misaligned_q;
            assign lost_w[i]          = lost;
        end
    endgenerate

    assign status_o = '{
        boot:          boot_w,
        train_in_req:  train_in_req_w,
        train_out_rdy: train_out_rdy_w,
        live:          live_w,
        misaligned:    misaligned_w
    };

    assign link_lost_o = lost_w;

endmodule

/* logic/autostart_sequencer.sv */
`timescale 1ns/1ps
`include "link_params.svh"

// walks the lanes that report train_out_rdy, one at a time, lowest first
// each lane gets a fixed lock interval, then its complete bit, then an event record
module autostart_sequencer
    import link_pkg::*;
(
    input  logic         sys_clk_i,
    input  logic         sys_clk_ok_i,
    input  link_status_t status_i,
    input  lane_mask_t   link_lost_i,
    // software enable, a cleared bit keeps that lane from ever being locked
    input  lane_mask_t   enable_mask_i,
    output lane_mask_t   train_complete_o,
    output bus_req_t     seq_req_o,
    input  logic         seq_gnt_i
);

    localparam int lock_w = $clog2(`LOCK_CYCLES + 1);

    seq_state_t        state_q;
    lane_idx_t         lane_q;
    logic [lock_w-1:0] lock_cnt_q;
    logic [7:0]        evt_cnt_q;
    lane_mask_t        complete_q;

    lane_mask_t        cand;
    logic              pick_valid;
    lane_idx_t         pick_lane;
    logic              lock_done;

    // candidates: ready, enabled and not yet locked
    always_comb begin
        cand       = status_i.train_out_rdy & enable_mask_i & ~complete_q;
        pick_valid = |cand;
        pick_lane  = '0;
        // scan downwards so the lowest set lane wins
        for (int l = `NUM_LANES - 1; l >= 0; l--) begin
            if (cand[l]) begin
                pick_lane = lane_idx_t'(l);
            end
        end
    end

    assign lock_done = (lock_cnt_q == lock_w'(`LOCK_CYCLES - 1));

    always_ff @(posedge sys_clk_i or negedge sys_clk_ok_i) begin
        if (!sys_clk_ok_i) begin
            state_q    <= SEQ_IDLE;
            lane_q     <= '0;
            lock_cnt_q <= '0;
            evt_cnt_q  <= '0;
            complete_q <= '0;
        end else begin
            // a lost lane has to go through training again
            complete_q <= complete_q & ~link_lost_i;
            case (state_q)
                SEQ_IDLE: begin
                    if (pick_valid) begin
                        lane_q     <= pick_lane;
                        lock_cnt_q <= '0;
                        state_q    <= SEQ_LOCK;
                    end
                end
                SEQ_LOCK: begin
                    if (link_lost_i[lane_q]) begin
                        // board dropped out mid-lock, give up on it
                        state_q <= SEQ_IDLE;
                    end else if (lock_done) begin
                        complete_q[lane_q] <= 1'b1;
                        evt_cnt_q          <= evt_cnt_q + 8'd1;
                        state_q            <= SEQ_LOG;
                    end else begin
                        lock_cnt_q <= lock_cnt_q + 1'b1;
                    end
                end
                SEQ_LOG, SEQ_WAIT_GNT: begin
                    // write stays posted until the arbiter lets it through
                    state_q <= seq_gnt_i ? SEQ_IDLE : SEQ_WAIT_GNT;
                end
                default: begin
                    state_q <= SEQ_IDLE;
                end
            endcase
        end
    end

    // event record layout matches REG_EVENT read-back
    always_comb begin
        seq_req_o       = '0;
        seq_req_o.wr    = (state_q == SEQ_LOG) || (state_q == SEQ_WAIT_GNT);
        seq_req_o.addr  = `REG_EVENT;
        seq_req_o.wdata = {16'h0000, evt_cnt_q, 5'b00000, lane_q};
    end

    assign train_complete_o = complete_q;

endmodule

/* logic/reg_bus_arbiter.sv */
`timescale 1ns/1ps

// the host port has no back-pressure, so any host strobe takes the bus
// the sequencer only gets through on cycles the host leaves empty
module reg_bus_arbiter
    import link_pkg::*;
(
    // host side, single cycle strobes
    input  bus_req_t host_req_i,
    // sequencer side, held until granted
    input  bus_req_t seq_req_i,
    output logic     seq_gnt_o,
    // towards the register file
    output bus_req_t bus_req_o
);

    logic host_active;
    logic seq_active;

    // a request only counts when it carries a strobe
    assign host_active = host_req_i.wr || host_req_i.rd;
    assign seq_active  = seq_req_i.wr || seq_req_i.rd;

    always_comb begin
        if (host_active) begin
            bus_req_o = host_req_i;
            seq_gnt_o = 1'b0;
        end else begin
            bus_req_o = seq_req_i;
            // grant in the same cycle the transfer reaches the registers
            seq_gnt_o = seq_active;
        end
    end

endmodule

/* logic/link_ctrl_regs.sv */
`timescale 1ns/1ps
`include "link_params.svh"

// four word register file on the shared bus
// control and event words are stored here, status words come straight from the detector
module link_ctrl_regs
    import link_pkg::*;
(
    input  logic         sys_clk_i,
    input  logic         sys_clk_ok_i,
    input  bus_req_t     bus_req_i,
    input  link_status_t status_i,
    output lane_mask_t   enable_mask_o,
    output reg_data_t    rd_data_o,
    // one cycle after the read strobe
    output logic         rd_valid_o
);

    lane_mask_t enable_q;
    lane_idx_t  evt_lane_q;
    logic [7:0] evt_cnt_q;
    reg_data_t  rd_mux;

    // control state and read handshake
    always_ff @(posedge sys_clk_i or negedge sys_clk_ok_i) begin
        if (!sys_clk_ok_i) begin
            // all lanes enabled out of reset so bring-up runs on its own
            enable_q   <= '1;
            evt_lane_q <= '0;
            evt_cnt_q  <= '0;
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= bus_req_i.rd;
            if (bus_req_i.wr) begin
                case (bus_req_i.addr)
                    `REG_CTRL: begin
                        enable_q <= bus_req_i.wdata[6:0];
                    end
                    `REG_EVENT: begin
                        evt_lane_q <= bus_req_i.wdata[2:0];
                        evt_cnt_q  <= bus_req_i.wdata[15:8];
                    end
                    // status and flags are read only
                    default: begin
                    end
                endcase
            end
        end
    end

    // read-back layout
    always_comb begin
        case (bus_req_i.addr)
            `REG_CTRL: begin
                rd_mux = {25'h0, enable_q};
            end
            `REG_STATUS: begin
                rd_mux = {17'h0, status_i.boot, 1'b0, status_i.live};
            end
            `REG_FLAGS: begin
                rd_mux = {9'h0, status_i.misaligned, 1'b0,
                          status_i.train_out_rdy, 1'b0, status_i.train_in_req};
            end
            default: begin
                rd_mux = {16'h0, evt_cnt_q, 5'b00000, evt_lane_q};
            end
        endcase
    end

    // capture only on a read strobe, holds until the next read
    always_ff @(posedge sys_clk_i) begin
        if (bus_req_i.rd) begin
            rd_data_o <= rd_mux;
        end
    end

    assign enable_mask_o = enable_q;

endmodule

/* logic/link_train_top.sv */
`timescale 1ns/1ps

// link bring-up for the seven digitizer boards
// detector -> sequencer -> arbiter -> register file, all on sys_clk
module link_train_top
    import link_pkg::*;
(
    input  logic                                   sys_clk_i,
    input  logic                                   sys_clk_ok_i,
    input  cout_code_t [$bits(lane_mask_t)-1:0]    cout_i,
    input  dout_code_t [$bits(lane_mask_t)-1:0]    dout_i,
    // host register port
    input  bus_req_t                               host_req_i,
    output reg_data_t                              rd_data_o,
    output logic                                   rd_valid_o,
    output link_status_t                           status_o
);

    link_status_t status;
    lane_mask_t   link_lost;
    lane_mask_t   train_complete;
    lane_mask_t   enable_mask;
    bus_req_t     seq_req;
    bus_req_t     bus_req;
    logic         seq_gnt;

    link_live_detector u_detector (
        .sys_clk_i       (sys_clk_i),
        .sys_clk_ok_i    (sys_clk_ok_i),
        .cout_i          (cout_i),
        .dout_i          (dout_i),
        .train_complete_i(train_complete),
        .status_o        (status),
        .link_lost_o     (link_lost)
    );

    autostart_sequencer u_sequencer (
        .sys_clk_i       (sys_clk_i),
        .sys_clk_ok_i    (sys_clk_ok_i),
        .status_i        (status),
        .link_lost_i     (link_lost),
        .enable_mask_i   (enable_mask),
        .train_complete_o(train_complete),
        .seq_req_o       (seq_req),
        .seq_gnt_i       (seq_gnt)
    );

    // host first, sequencer takes the idle cycles
    reg_bus_arbiter u_arbiter (
        .host_req_i(host_req_i),
        .seq_req_i (seq_req),
        .seq_gnt_o (seq_gnt),
        .bus_req_o (bus_req)
    );

    link_ctrl_regs u_regs (
        .sys_clk_i    (sys_clk_i),
        .sys_clk_ok_i (sys_clk_ok_i),
        .bus_req_i    (bus_req),
        .status_i     (status),
        .enable_mask_o(enable_mask),
        .rd_data_o    (rd_data_o),
        .rd_valid_o   (rd_valid_o)
    );

    assign status_o = status;

endmodule

/* verification/link_train_properties.sv */
`timescale 1ns/1ps
`include "link_params.svh"

// lane and read handshake timing on link_train_top
module link_train_properties
    import link_pkg::*;
(
    input logic                        sys_clk_i,
    input logic                        sys_clk_ok_i,
    input cout_code_t [`NUM_LANES-1:0] cout_i,
    input dout_code_t [`NUM_LANES-1:0] dout_i,
    input bus_req_t                    host_req_i,
    input logic                        rd_valid_i,
    input link_status_t                status_i,
    input lane_mask_t                  link_lost_i,
    input lane_mask_t                  train_complete_i
);

    // failures so far, read by the testbench at the end
    int fail_count = 0;

    genvar i;
    generate
        for (i = 0; i < `NUM_LANES; i = i + 1) begin : g_lane
            a_train_in_req: assert property (@(posedge sys_clk_i) disable iff (!sys_clk_ok_i)
                status_i.boot[i] && dout_i[i] == 8'h00 && !link_lost_i[i]
                |=> status_i.train_in_req[i])
            else begin
                $error("lane %0d: train_in_req did not follow DOUT 0x00", i);
                fail_count++;
            end

            a_train_out_rdy: assert property (@(posedge sys_clk_i) disable iff (!sys_clk_ok_i)
                status_i.train_in_req[i] && cout_i[i] != 4'hF && !link_lost_i[i]
                |=> status_i.train_out_rdy[i])
            else begin
                $error("lane %0d: train_out_rdy did not follow COUT", i);
                fail_count++;
            end

            a_misaligned_sticky: assert property (@(posedge sys_clk_i) disable iff (!sys_clk_ok_i)
                status_i.misaligned[i] |=> status_i.misaligned[i])
            else begin
                $error("lane %0d: misaligned cleared without reset", i);
                fail_count++;
            end

            a_loss_clear: assert property (@(posedge sys_clk_i) disable iff (!sys_clk_ok_i)
                link_lost_i[i] |=> !status_i.live[i] && !status_i.train_in_req[i] &&
                                   !status_i.train_out_rdy[i] && status_i.boot[i])
            else begin
                $error("lane %0d: state not cleared one cycle after loss", i);
                fail_count++;
            end

            // live can only rise on a lane the sequencer has locked
            a_live_needs_complete: assert property (@(posedge sys_clk_i)
                disable iff (!sys_clk_ok_i)
                !status_i.live[i] && !train_complete_i[i] |=> !status_i.live[i])
            else begin
                $error("lane %0d: live rose without train_complete", i);
                fail_count++;
            end
        end
    endgenerate

    a_rd_valid: assert property (@(posedge sys_clk_i) disable iff (!sys_clk_ok_i)
        host_req_i.rd |=> rd_valid_i)
    else begin
        $error("host read strobe not answered by rd_valid one cycle later");
        fail_count++;
    end

endmodule

bind link_train_top link_train_properties u_props (
    .sys_clk_i       (sys_clk_i),
    .sys_clk_ok_i    (sys_clk_ok_i),
    .cout_i          (cout_i),
    .dout_i          (dout_i),
    .host_req_i      (host_req_i),
    .rd_valid_i      (rd_valid_o),
    .status_i        (status),
    .link_lost_i     (link_lost),
    .train_complete_i(train_complete)
);

/* verification/link_train_tb.sv */
`timescale 1ns/1ps
`include "link_params.svh"

// brings lanes up one by one and reads the register file back
// lane timing rules are watched by the bound property module
module link_train_tb
    import link_pkg::*;
();

    // selectors for lane_flag
    localparam int fld_boot     = 0;
    localparam int fld_in_req   = 1;
    localparam int fld_rdy      = 2;
    localparam int fld_live     = 3;
    localparam int fld_mis      = 4;
    localparam int fld_complete = 5;

    logic                        sys_clk_i;
    logic                        sys_clk_ok_i;
    cout_code_t [`NUM_LANES-1:0] cout;
    dout_code_t [`NUM_LANES-1:0] dout;
    bus_req_t                    host_req;
    reg_data_t                   rd_data;
    logic                        rd_valid;
    link_status_t                status;

    int          reg_errors;
    int          timeouts;
    int          lane_order[`NUM_LANES];
    int          lane_a;
    int          lane_b;
    int          lane_c;
    int          tmp;
    int          j;
    dout_code_t  mis_value;
    lane_mask_t  ctrl_mask;
    // expected link state, one bit per lane
    lane_mask_t  exp_boot;
    lane_mask_t  exp_in_req;
    lane_mask_t  exp_rdy;
    lane_mask_t  exp_live;
    lane_mask_t  exp_mis;

    link_train_top u_dut (
        .sys_clk_i   (sys_clk_i),
        .sys_clk_ok_i(sys_clk_ok_i),
        .cout_i      (cout),
        .dout_i      (dout),
        .host_req_i  (host_req),
        .rd_data_o   (rd_data),
        .rd_valid_o  (rd_valid),
        .status_o    (status)
    );

    initial sys_clk_i = 1'b0;
    always #4 sys_clk_i = ~sys_clk_i;

    // live in 6:0, boot in 14:8
    function automatic reg_data_t status_word();
        return (reg_data_t'(exp_boot) << 8) | reg_data_t'(exp_live);
    endfunction

    // train_in_req in 6:0, train_out_rdy in 14:8, misaligned in 22:16
    function automatic reg_data_t flags_word();
        return (reg_data_t'(exp_mis) << 16) | (reg_data_t'(exp_rdy) << 8) |
               reg_data_t'(exp_in_req);
    endfunction

    function automatic reg_data_t event_word(input int lane, input int count);
        return (reg_data_t'(count) << 8) | reg_data_t'(lane);
    endfunction

    function automatic logic lane_flag(input int field, input int lane);
        case (field)
            fld_boot:   return status.boot[lane];
            fld_in_req: return status.train_in_req[lane];
            fld_rdy:    return status.train_out_rdy[lane];
            fld_live:   return status.live[lane];
            fld_mis:    return status.misaligned[lane];
            default:    return u_dut.train_complete[lane];
        endcase
    endfunction

    task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
        @(posedge sys_clk_i);
        host_req <= '{wr: 1'b1, rd: 1'b0, addr: addr, wdata: data};
        @(posedge sys_clk_i);
        host_req <= '0;
    endtask

    task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
        int   n;
        logic seen;
        @(posedge sys_clk_i);
        host_req <= '{wr: 1'b0, rd: 1'b1, addr: addr, wdata: '0};
        @(posedge sys_clk_i);
        host_req <= '0;
        seen = 1'b0;
        data = 'x;
        for (n = 0; n < 8 && !seen; n++) begin
            @(negedge sys_clk_i);
            if (rd_valid) begin
                seen = 1'b1;
                data = rd_data;
            end
        end
        if (!seen) begin
            $display("timeout: read of register %0d never returned valid data", addr);
            timeouts++;
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t addr, input reg_data_t expected);
        reg_data_t actual;
        read_reg(addr, actual);
        if (actual !== expected) begin
            $display("Error %s: expected %h, actual %h", name, expected, actual);
            reg_errors++;
        end
    endtask

    task automatic wait_flag(input string what, input int field, input int lane,
                             input logic value, input int limit);
        int   n;
        logic seen;
        seen = 1'b0;
        for (n = 0; n < limit && !seen; n++) begin
            @(negedge sys_clk_i);
            seen = (lane_flag(field, lane) === value);
        end
        if (!seen) begin
            $display("timeout: %s on lane %0d never reached %0b", what, lane, value);
            timeouts++;
        end
    endtask

    // host reads every cycle while the lane locks, so the event write has to wait
    task automatic wait_complete_reading(input int lane, input int limit);
        int   n;
        logic seen;
        seen = 1'b0;
        for (n = 0; n < limit && !seen; n++) begin
            @(posedge sys_clk_i);
            host_req <= '{wr: 1'b0, rd: 1'b1, addr: `REG_FLAGS, wdata: '0};
            @(negedge sys_clk_i);
            seen = u_dut.train_complete[lane];
        end
        repeat (3) begin
            @(posedge sys_clk_i);
            host_req <= '{wr: 1'b0, rd: 1'b1, addr: `REG_FLAGS, wdata: '0};
        end
        @(posedge sys_clk_i);
        host_req <= '0;
        if (!seen) begin
            $display("timeout: lane %0d never completed training under host reads", lane);
            timeouts++;
        end
    endtask

    // DOUT 0x00 asks for training, COUT leaves all ones, DOUT holds 0x6A until locked
    task automatic bring_up(input int lane, input dout_code_t final_dout,
                            input bit enabled, input bit read_during_lock);
        @(posedge sys_clk_i);
        dout[lane] <= 8'h00;
        wait_flag("train_in_req", fld_in_req, lane, 1'b1, 16);
        @(posedge sys_clk_i);
        dout[lane] <= `DOUT_TRAIN;
        cout[lane] <= 4'h5;
        wait_flag("train_out_rdy", fld_rdy, lane, 1'b1, 16);
        exp_in_req[lane] = 1'b1;
        exp_rdy[lane]    = 1'b1;
        if (!enabled) begin
            repeat (4 * `LOCK_CYCLES) @(posedge sys_clk_i);
        end else if (read_during_lock) begin
            wait_complete_reading(lane, 8 * `LOCK_CYCLES);
        end else begin
            wait_flag("train_complete", fld_complete, lane, 1'b1, 8 * `LOCK_CYCLES);
        end
        @(posedge sys_clk_i);
        dout[lane] <= final_dout;
        if (enabled) begin
            wait_flag("live", fld_live, lane, 1'b1, 16);
            exp_live[lane] = 1'b1;
            exp_mis[lane]  = (final_dout != 8'h00);
        end else begin
            repeat (8) @(posedge sys_clk_i);
        end
    endtask

    initial begin
        sys_clk_ok_i = 1'b0;
        cout         = '1;
        dout         = {`NUM_LANES{`DOUT_TRAIN}};
        host_req     = '0;
        reg_errors   = 0;
        timeouts     = 0;
        exp_boot     = '0;
        exp_in_req   = '0;
        exp_rdy      = '0;
        exp_live     = '0;
        exp_mis      = '0;

        void'($urandom(32'hf1c2_1859));
        for (int l = 0; l < `NUM_LANES; l++) begin
            lane_order[l] = l;
        end
        for (int l = `NUM_LANES - 1; l > 0; l--) begin
            j             = $urandom_range(l, 0);
            tmp           = lane_order[l];
            lane_order[l] = lane_order[j];
            lane_order[j] = tmp;
        end
        lane_a    = lane_order[0];
        lane_b    = lane_order[1];
        lane_c    = lane_order[2];
        mis_value = dout_code_t'($urandom_range(255, 1));
        if (mis_value == `DOUT_TRAIN) begin
            mis_value = 8'h5A;
        end

        repeat (3) @(posedge sys_clk_i);
        sys_clk_ok_i <= 1'b1;

        // COUT starts all ones, so every lane passes the loss rule into boot
        for (int l = 0; l < `NUM_LANES; l++) begin
            wait_flag("boot", fld_boot, l, 1'b1, 3 * `COUT_LOSS_COUNT);
        end
        exp_boot = '1;
        check_reg("boot_status", `REG_STATUS, status_word());

        ctrl_mask         = '1;
        ctrl_mask[lane_c] = 1'b0;
        write_reg(`REG_CTRL, reg_data_t'(ctrl_mask));
        check_reg("enable_mask", `REG_CTRL, reg_data_t'(ctrl_mask));
        // status words are read only, a write must not land in the stored registers
        write_reg(`REG_STATUS, 32'hffff_ffff);
        check_reg("status_write_ctrl", `REG_CTRL, reg_data_t'(ctrl_mask));
        check_reg("status_write_event", `REG_EVENT, event_word(0, 0));

        bring_up(lane_a, 8'h00, 1'b1, 1'b0);
        check_reg("clean_status", `REG_STATUS, status_word());
        check_reg("clean_flags", `REG_FLAGS, flags_word());
        check_reg("clean_event", `REG_EVENT, event_word(lane_a, 1));

        bring_up(lane_b, mis_value, 1'b1, 1'b1);
        check_reg("misaligned_flags", `REG_FLAGS, flags_word());
        check_reg("misaligned_status", `REG_STATUS, status_word());
        check_reg("misaligned_event", `REG_EVENT, event_word(lane_b, 2));

        bring_up(lane_c, 8'h00, 1'b0, 1'b0);
        check_reg("masked_status", `REG_STATUS, status_word());
        check_reg("masked_flags", `REG_FLAGS, flags_word());
        check_reg("masked_event", `REG_EVENT, event_word(lane_b, 2))

;

        // a live lane whose COUT sticks at all ones is lost
        // DOUT back on the idle pattern so the lane does not ask for training again
        @(posedge sys_clk_i);
        cout[lane_a] <= 4'hF;
        dout[lane_a] <= `DOUT_TRAIN;
        wait_flag("live", fld_live, lane_a, 1'b0, 3 * `COUT_LOSS_COUNT);
        exp_live[lane_a]   = 1'b0;
        exp_in_req[lane_a] = 1'b0;
        exp_rdy[lane_a]    = 1'b0;
        check_reg("loss_status", `REG_STATUS, status_word());
        check_reg("loss_flags", `REG_FLAGS, flags_word());

        repeat (4) @(posedge sys_clk_i);
        $display("register errors: %0d, timeouts: %0d, assertion errors: %0d",
                 reg_errors, timeouts, u_dut.u_props.fail_count);
        if (reg_errors + timeouts + u_dut.u_props.fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+logic
logic/link_pkg.sv
logic/link_live_detector.sv
logic/autostart_sequencer.sv
logic/reg_bus_arbiter.sv
logic/link_ctrl_regs.sv
logic/link_train_top.sv
verification/link_train_properties.sv
verification/link_train_tb.sv

/* Bender.yml */
package:
  name: link_train

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/link_pkg.sv
      - logic/link_live_detector.sv
      - logic/autostart_sequencer.sv
      - logic/reg_bus_arbiter.sv
      - logic/link_ctrl_regs.sv
      - logic/link_train_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/link_train_properties.sv
      - verification/link_train_tb.sv
